// File: hw/core_pkg.sv
package core_pkg;

    // data and address width
    parameter int xlen = 32;

    // major opcodes handled by the exec unit
    parameter logic [6:0] op_imm    = 7'b0010011;
    parameter logic [6:0] op_reg    = 7'b0110011;
    parameter logic [6:0] op_system = 7'b1110011;

    // add/addi share funct3, sub is picked out by funct7
    parameter logic [2:0] f3_add = 3'b000;
    parameter logic [6:0] f7_sub = 7'b0100000;

    // full ecall encoding, everything but the opcode is zero
    parameter logic [31:0] ecall_word = 32'h00000073;

    // one instruction word, seen either as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } inst_t;

endpackage

// File: hw/time_counter.sv
`timescale 1ns/1ps

module time_counter #(
    parameter int FMAX_MHz = 18
) (
    input  logic        clkConstrained,
    input  logic        rst_n,
    output logic [63:0] reg_cycle,
    output logic [63:0] reg_time
);

    // prescaler needs at least one bit even for a 1 MHz clock
    localparam int pre_w = (FMAX_MHz > 1) ? $clog2(FMAX_MHz) : 1;
    localparam logic [pre_w-1:0] pre_last = pre_w'(FMAX_MHz - 1);

    logic [pre_w-1:0] prescale;

    // cycle count, one per clock
    always_ff @(posedge clkConstrained or negedge rst_n) begin
        if (!rst_n) begin
            reg_cycle <= '0;
        end else begin
            reg_cycle <= reg_cycle + 64'd1;
        end
    end

    // microsecond count, bumped when the prescaler wraps
    always_ff @(posedge clkConstrained or negedge rst_n) begin
        if (!rst_n) begin
            prescale <= '0;
            reg_time <= '0;
        end else begin
            if (prescale == pre_last) begin
                prescale <= '0;
                reg_time <= reg_time + 64'd1;
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

    // reg_time tracks reg_cycle / FMAX_MHz at every edge

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                     clkConstrained,
    input  logic                     rst_n,

    // instruction memory, four-phase req/ack
    output logic                     imem_req,
    output logic [core_pkg::xlen-1:0] imem_addr,
    input  logic                     imem_ack,
    input  logic [core_pkg::xlen-1:0] imem_rdata,

    // queue write side
    output logic                     push,
    output logic [core_pkg::xlen-1:0] push_data,
    input  logic                     full,

    // stop fetching after ecall
    input  logic                     exited
);

    // handshake phases
    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_request = 2'd1;
    localparam logic [1:0] st_release = 2'd2;

    logic [1:0]                state;
    logic [core_pkg::xlen-1:0] pc;

    always_ff @(posedge clkConstrained or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            pc    <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // a free slot stays free until our own push
                    if (!full && !exited) begin
                        state <= st_request;
                    end
                end
                st_request: begin
                    // word is captured this cycle, req drops next
                    if (imem_ack) begin
                        state <= st_release;
                        pc    <= pc + core_pkg::xlen'(4);
                    end
                end
                st_release: begin
                    // wait for memory to drop ack before the next req
                    if (!imem_ack) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // req held with a stable address for the whole request phase
    assign imem_req  = (state == st_request);
    assign imem_addr = pc;

    // push in the cycle ack is seen with req still high
    assign push      = (state == st_request) && imem_ack;
    assign push_data = imem_rdata;

endmodule

// File: hw/inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                      clkConstrained,
    input  logic                      rst_n,

    input  logic                      push,
    input  logic [core_pkg::xlen-1:0] push_data,
    input  logic                      pop,
    output logic [core_pkg::xlen-1:0] pop_data,

    output logic                      full,
    output logic                      empty
);

    localparam int ptr_w = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int cnt_w = $clog2(QUEUE_DEPTH + 1);

    logic [core_pkg::xlen-1:0] mem [0:QUEUE_DEPTH-1];
    logic [ptr_w-1:0]          wr_ptr;
    logic [ptr_w-1:0]          rd_ptr;
    logic [cnt_w-1:0]          count;

    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // storage, written only on an accepted push
    always_ff @(posedge clkConstrained) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap explicitly at the last slot
    always_ff @(posedge clkConstrained or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // head of queue, valid whenever empty is low
    assign pop_data = mem[rd_ptr];

    assign full  = (count == cnt_w'(QUEUE_DEPTH));
    assign empty = (count == '0);

endmodule

// File: hw/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                      clkConstrained,
    input  logic                      rst_n,

    // queue read side
    output logic                      pop,
    input  logic [core_pkg::xlen-1:0] pop_data,
    input  logic                      empty,

    // status
    output logic                      exited,
    output logic [core_pkg::xlen-1:0] gp,
    output logic [5:0]                led
);

    core_pkg::inst_t inst;

    logic [core_pkg::xlen-1:0] regs [0:31];

    logic [core_pkg::xlen-1:0] rs1_val;
    logic [core_pkg::xlen-1:0] rs2_val;
    logic [core_pkg::xlen-1:0] imm_ext;

    logic                      wr_en;
    logic [4:0]                wr_idx;
    logic [core_pkg::xlen-1:0] wr_data;
    logic                      is_ecall;

    // one instruction per cycle while words are waiting
    assign pop  = !empty && !exited;
    assign inst = pop_data;

    // operand reads, x0 always reads as zero
    assign rs1_val = (inst.r.rs1 == 5'd0) ? '0 : regs[inst.r.rs1];
    assign rs2_val = (inst.r.rs2 == 5'd0) ? '0 : regs[inst.r.rs2];

    // sign-extended I-type immediate
    assign imm_ext = {{(core_pkg::xlen - 12){inst.i.imm[11]}}, inst.i.imm};

    // rd sits in the same place in both views
    assign wr_idx = inst.r.rd;

    // decode, anything not listed retires as a no-op
    always_comb begin
        wr_en    = 1'b0;
        wr_data  = '0;
        is_ecall = 1'b0;
        case (inst.r.opcode)
            core_pkg::op_imm: begin
                if (inst.i.funct3 == core_pkg::f3_add) begin
                    wr_en   = 1'b1;
                    wr_data = rs1_val + imm_ext;
                end
            end
            core_pkg::op_reg: begin
                if (inst.r.funct3 == core_pkg::f3_add) begin
                    if (inst.r.funct7 == core_pkg::f7_sub) begin
                        wr_en   = 1'b1;
                        wr_data = rs1_val - rs2_val;
                    end else if (inst.r.funct7 == 7'd0) begin
                        wr_en   = 1'b1;
                        wr_data = rs1_val + rs2_val;
                    end
                end
            end
            core_pkg::op_system: begin
                // only a plain ecall ends the run, ebreak and csr ops fall through
                if (inst == core_pkg::ecall_word) begin
                    is_ecall = 1'b1;
                end
            end
            default: begin
                wr_en = 1'b0;
            end
        endcase
    end

    // register file, written at the edge that ends the pop cycle
    always_ff @(posedge clkConstrained or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else begin
            if (pop && wr_en && (wr_idx != 5'd0)) begin
                regs[wr_idx] <= wr_data;
            end
        end
    end

    // sticky exit flag
    always_ff @(posedge clkConstrained or negedge rst_n) begin
        if (!rst_n) begin
            exited <= 1'b0;
        end else begin
            if (pop && is_ecall) begin
                exited <= 1'b1;
            end
        end
    end

    // gp is x3, leds are active low
    assign gp  = regs[3];
    assign led = ~gp[5:0];

endmodule

// File: hw/soc_top.sv
`timescale 1ns/1ps

module soc_top #(
    parameter int FMAX_MHz    = 18,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                      clkConstrained,
    input  logic                      rst_n,

    // instruction memory
    output logic                      imem_req,
    output logic [core_pkg::xlen-1:0] imem_addr,
    input  logic                      imem_ack,
    input  logic [core_pkg::xlen-1:0] imem_rdata,

    // status
    output logic [core_pkg::xlen-1:0] gp,
    output logic [5:0]                led,
    output logic                      exit,

    // counters
    output logic [63:0]               reg_cycle,
    output logic [63:0]               reg_time
);

    logic                      push;
    logic [core_pkg::xlen-1:0] push_data;
    logic                      pop;
    logic [core_pkg::xlen-1:0] pop_data;
    logic                      full;
    logic                      empty;

    time_counter #(
        .FMAX_MHz(FMAX_MHz)
    ) i_time_counter (
        .clkConstrained(clkConstrained),
        .rst_n         (rst_n),
        .reg_cycle     (reg_cycle),
        .reg_time      (reg_time)
    );

    // exit from the exec unit also halts fetching
    fetch_unit i_fetch_unit (
        .clkConstrained(clkConstrained),
        .rst_n         (rst_n),
        .imem_req      (imem_req),
        .imem_addr     (imem_addr),
        .imem_ack      (imem_ack),
        .imem_rdata    (imem_rdata),
        .push          (push),
        .push_data     (push_data),
        .full          (full),
        .exited        (exit)
    );

    inst_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_inst_queue (
        .clkConstrained(clkConstrained),
        .rst_n         (rst_n),
        .push          (push),
        .push_data     (push_data),
        .pop           (pop),
        .pop_data      (pop_data),
        .full          (full),
        .empty         (empty)
    );

    exec_unit i_exec_unit (
        .clkConstrained(clkConstrained),
        .rst_n         (rst_n),
        .pop           (pop),
        .pop_data      (pop_data),
        .empty         (empty),
        .exited        (exit),
        .gp            (gp),
        .led           (led)
    );

endmodule

// File: testbench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ADDI rd, rs1, imm
function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, core_pkg::f3_add, rd, core_pkg::op_imm};
endfunction

// ADD, or SUB when sub is set
function automatic logic [31:0] reg_op_word(input logic sub, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
    logic [6:0] funct7;
    funct7 = sub ? core_pkg::f7_sub : 7'd0;
    return {funct7, rs2, rs1, core_pkg::f3_add, rd, core_pkg::op_reg};
endfunction

// random bits under an opcode the core does not implement
function automatic logic [31:0] junk_word();
    logic [31:0] w;
    w = $urandom();
    case ($urandom_range(2, 0))
        0: w[6:0] = 7'b0000011;
        1: w[6:0] = 7'b0100011;
        default: w[6:0] = 7'b1100011;
    endcase
    return w;
endfunction

// word seen at a byte address, ecall past the end
function automatic logic [31:0] word_at(input logic [31:0] addr);
    if ((addr >> 2) < 32'(prog.size())) begin
        return prog[addr >> 2];
    end
    return core_pkg::ecall_word;
endfunction

function automatic void fill_directed();
    prog.delete();
    prog.push_back(addi_word(5'd3, 5'd0, 12'd100));
    prog.push_back(addi_word(5'd3, 5'd3, 12'(-37)));
    // write to x0 has to be dropped
    prog.push_back(addi_word(5'd0, 5'd0, 12'd55));
    prog.push_back(reg_op_word(1'b0, 5'd3, 5'd3, 5'd0));
    prog.push_back(addi_word(5'd3, 5'd3, 12'h800));
    prog.push_back(addi_word(5'd5, 5'd0, 12'd45));
    prog.push_back(reg_op_word(1'b1, 5'd3, 5'd3, 5'd5));
    prog.push_back(core_pkg::ecall_word);
endfunction

function automatic void fill_random(input int count);
    prog.delete();
    for (int n = 0; n < count; n++) begin
        case ($urandom_range(3, 0))
            0: prog.push_back(addi_word(5'($urandom_range(7, 0)), 5'($urandom_range(7, 0)),
                                        12'($urandom())));
            1: prog.push_back(reg_op_word(1'b0, 5'($urandom_range(7, 0)),
                                          5'($urandom_range(7, 0)), 5'($urandom_range(7, 0))));
            2: prog.push_back(reg_op_word(1'b1, 5'($urandom_range(7, 0)),
                                          5'($urandom_range(7, 0)), 5'($urandom_range(7, 0))));
            default: prog.push_back(junk_word());
        endcase
    end
    prog.push_back(core_pkg::ecall_word);
endfunction

// runs the program on a model register file, returns x3
function automatic logic [31:0] expected_gp(input logic [31:0] words [$]);
    logic [31:0] regs [32];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    for (int k = 0; k < 32; k++) begin
        regs[k] = '0;
    end
    for (int idx = 0; idx <= words.size(); idx++) begin
        w = (idx < words.size()) ? words[idx] : core_pkg::ecall_word;
        if (w == core_pkg::ecall_word) begin
            break;
        end
        a   = regs[w[19:15]];
        b   = regs[w[24:20]];
        imm = {{20{w[31]}}, w[31:20]};
        if (w[6:0] == core_pkg::op_imm && w[14:12] == core_pkg::f3_add) begin
            regs[w[11:7]] = a + imm;
        end else if (w[6:0] == core_pkg::op_reg && w[14:12] == core_pkg::f3_add) begin
            if (w[31:25] == 7'd0) begin
                regs[w[11:7]] = a + b;
            end else if (w[31:25] == core_pkg::f7_sub) begin
                regs[w[11:7]] = a - b;
            end
        end
        // x0 stays zero
        regs[0] = '0;
    end
    return regs[3];
endfunction

`endif

// File: testbench/tb_soc_top.sv
`timescale 1ns/1ps

module tb_soc_top;

    localparam int fmax_mhz    = 18;
    localparam int queue_depth = 4;

    logic        clkConstrained;
    logic        rst_n;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_ack;
    logic [31:0] imem_rdata;
    logic [31:0] gp;
    logic [5:0]  led;
    logic        exit;
    logic [63:0] reg_cycle;
    logic [63:0] reg_time;

    // program image served by the memory responder
    logic [31:0] prog [$];
    logic [31:0] next_addr;
    int          max_delay = 5;

    int tb_cycles = 0;
    int run_start = 0;
    int run_limit = 1000;
    int errors    = 0;

    `include "tb_program.svh"

    soc_top #(
        .FMAX_MHz   (fmax_mhz),
        .QUEUE_DEPTH(queue_depth)
    ) i_soc_top (
        .clkConstrained(clkConstrained),
        .rst_n         (rst_n),
        .imem_req      (imem_req),
        .imem_addr     (imem_addr),
        .imem_ack      (imem_ack),
        .imem_rdata    (imem_rdata),
        .gp            (gp),
        .led           (led),
        .exit          (exit),
        .reg_cycle     (reg_cycle),
        .reg_time      (reg_time)
    );

    initial begin
        clkConstrained = 1'b0;
        forever begin
            #10 clkConstrained = ~clkConstrained;
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string why);
        errors++;
        $display("%s at time %0t", why, $time);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // four-phase memory responder with a random ack delay
    initial begin
        int delay;
        imem_ack   = 1'b0;
        imem_rdata = '0;
        next_addr  = '0;
        forever begin
            @(negedge clkConstrained);
            if (!rst_n) begin
                next_addr = '0;
            end else if (imem_req && !imem_ack) begin
                check_value("imem_addr", 64'(imem_addr), 64'(next_addr));
                delay = $urandom_range(max_delay, 0);
                repeat (delay) @(negedge clkConstrained);
                imem_rdata = word_at(imem_addr);
                imem_ack   = 1'b1;
                next_addr  = next_addr + 32'd4;
                @(negedge clkConstrained);
                while (imem_req) @(negedge clkConstrained);
                imem_ack = 1'b0;
            end
        end
    end

    // budget per run follows the program length
    initial begin
        forever begin
            @(negedge clkConstrained);
            tb_cycles++;
            if (tb_cycles - run_start > run_limit) begin
                errors++;
                $display("Timeout: the program did not finish within %0d cycles", run_limit);
                $display("TEST FAIL");
                $fatal(1);
            end
        end
    end

    task automatic run_program(input int delay_max, input logic [31:0] exp_gp,
                               output logic [31:0] seen_gp);
        logic [31:0] addr_at_exit;
        logic [31:0] addr_settled;
        logic [5:0]  exp_led;
        int          cyc;
        exp_led   = ~exp_gp[5:0];
        max_delay = delay_max;
        run_start = tb_cycles;
        run_limit = 40 * prog.size() + 200;
        @(negedge clkConstrained);
        rst_n = 1'b0;
        repeat (2) @(negedge clkConstrained);
        // reset values before any ack
        check_value("imem_req", 64'(imem_req), 64'(1'b0));
        check_value("exit", 64'(exit), 64'(1'b0));
        check_value("gp", 64'(gp), 64'(32'd0));
        check_value("led", 64'(led), 64'(6'h3f));
        cyc   = 0;
        rst_n = 1'b1;
        while (!exit) begin
            @(negedge clkConstrained);
            // clock edges seen since reset release
            cyc++;
            if ($urandom_range(3, 0) == 0) begin
                check_value("reg_cycle", reg_cycle, 64'(cyc));
                check_value("reg_time", reg_time, 64'(cyc / fmax_mhz));
            end
        end
        seen_gp      = gp;
        addr_at_exit = imem_addr;
        check_value("led", 64'(led), 64'(exp_led));
        // one handshake may still be in flight
        repeat (4 * delay_max + 20) begin
            @(negedge clkConstrained);
            check_value("exit", 64'(exit), 64'(1'b1));
        end
        if (imem_addr - addr_at_exit > 32'd4) begin
            report_failure("More than one instruction fetch completed after exit");
        end
        addr_settled = imem_addr;
        repeat (10) begin
            @(negedge clkConstrained);
            check_value("exit", 64'(exit), 64'(1'b1));
        end
        check_value("imem_addr", 64'(imem_addr), 64'(addr_settled));
        check_value("imem_req", 64'(imem_req), 64'(1'b0));
    endtask

    initial begin
        logic [31:0] exp_gp;
        logic [31:0] got_gp;
        logic [31:0] got_fast;
        logic [31:0] got_slow;
        void'($urandom(32'h83d1));
        rst_n = 1'b0;

        fill_directed();
        exp_gp = expected_gp(prog);
        run_program(5, exp_gp, got_gp);
        check_value("gp", 64'(got_gp), 64'(exp_gp));

        fill_random(40);
        exp_gp = expected_gp(prog);
        run_program(5, exp_gp, got_gp);
        check_value("gp", 64'(got_gp), 64'(exp_gp));

        // same program under immediate ack and then slow memory
        run_program(0, exp_gp, got_fast);
        check_value("gp", 64'(got_fast), 64'(exp_gp));
        run_program(12, exp_gp, got_slow);
        check_value("gp", 64'(got_slow), 64'(got_fast));

        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+testbench
hw/core_pkg.sv
hw/time_counter.sv
hw/fetch_unit.sv
hw/inst_queue.sv
hw/exec_unit.sv
hw/soc_top.sv
testbench/tb_soc_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_soc_top
FILELIST  = list.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJDIR)
